// File: Makefile
SIM        = verilator
TOP        = credit_link_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing -Wall
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/credit_link_assert.sv
// Link protocol assertions
`timescale 1ns/1ns

module credit_link_assert (
  input logic                 clk,
  input logic                 arst_n,
  input flit_pkg::flow_mask_t push_valid,
  input flit_pkg::flow_mask_t push_ready,
  input flit_pkg::flow_mask_t link_valid,
  input credit_pkg::credit_t  credit_available,
  input logic                 sender_in_reset,
  input logic                 receiver_in_reset
);

  // Number of assertion failures so far.
  int failures = 0;

  // ----------------------------------------
  // Link rules seen at the sender
  // ----------------------------------------

  // A flit may only leave against at least one spendable credit.
  valid_needs_credit: assert property (
    @(posedge clk) disable iff (!arst_n)
    (link_valid != '0) |-> (credit_available != '0)
  ) else begin
    failures++;
    $error("link valid sent while no credit was available");
  end

  // Push handshakes reach the link in the same cycle. Outside reset every
  // requesting flow is sent while credit lasts, so the link carries only
  // requested flows, as many as the smaller of requests and spendable credit.
  valid_is_handshake: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(sender_in_reset || receiver_in_reset) |->
      (((link_valid & ~push_valid) == '0) &&
       ($countones(link_valid) ==
        ((int'(credit_available) < $countones(push_valid)) ?
         int'(credit_available) : $countones(push_valid))))
  ) else begin
    failures++;
    $error("link valid does not follow the push requests and the spendable credit");
  end

  // The sender stops accepting flits while the receiver is in reset.
  no_ready_in_reset: assert property (
    @(posedge clk) disable iff (!arst_n)
    receiver_in_reset |-> (push_ready == '0)
  ) else begin
    failures++;
    $error("push ready raised while the receiver is in reset");
  end

endmodule

bind credit_sender credit_link_assert credit_link_assert_i (
  .clk               (clk),
  .arst_n            (arst_n),
  .push_valid        (push_valid),
  .push_ready        (push_ready),
  .link_valid        (link.valid),
  .credit_available  (credit_available),
  .sender_in_reset   (link.sender_in_reset),
  .receiver_in_reset (link.receiver_in_reset)
);

// File: tests/credit_link_checker.sv
// Credit link scoreboard
`timescale 1ns/1ns

module credit_link_checker (
  input  logic                                           clk,
  input  logic                                           arst_n,
  input  logic                                           receiver_reset,
  input  flit_pkg::flow_mask_t                           push_valid,
  input  flit_pkg::flow_mask_t                           push_ready,
  input  flit_pkg::flit_data_t [flit_pkg::NUM_FLOWS-1:0] push_data,
  input  credit_pkg::credit_t                            credit_withhold,
  input  flit_pkg::flow_mask_t                           pop_ready,
  input  flit_pkg::flow_mask_t                           pop_valid,
  input  flit_pkg::flit_data_t [flit_pkg::NUM_FLOWS-1:0] pop_data,
  input  credit_pkg::credit_t                            credit_count,
  input  credit_pkg::credit_t                            credit_available,
  output int                                             mismatch_count,
  output int                                             error_count,
  output int                                             in_flight
);
  import flit_pkg::*;
  import credit_pkg::*;

  localparam int EXP_DEPTH = 16;

  // Expected flits per flow, in push order, as circular buffers.
  flit_data_t exp_mem [NUM_FLOWS][EXP_DEPTH];
  int         exp_wr [NUM_FLOWS] = '{default: 0};
  int         exp_rd [NUM_FLOWS] = '{default: 0};
  // Grants given to other flows while a flow keeps waiting.
  int         wait_grants [NUM_FLOWS] = '{default: 0};
  int         outstanding = 0;
  int         prev_pops = 0;
  int         mismatches = 0;
  int         errors = 0;
  logic       seen_reset = 1'b0;
  logic       rr_prev = 1'b0;

  // Flits in the receiver are lost on any reset.
  task automatic clear_expected();
    for (int f = 0; f < NUM_FLOWS; f++) begin
      exp_rd[f] = exp_wr[f];
      wait_grants[f] = 0;
    end
    outstanding = 0;
  endtask

  // ----------------------------------------
  // Per-cycle checks, sampled mid-cycle
  // ----------------------------------------

  always @(negedge clk) begin
    int pops_now;
    int grants_now;
    int exp_avail;
    pops_now = 0;
    grants_now = 0;
    if (!arst_n) begin
      seen_reset = 1'b1;
      clear_expected();
      prev_pops = 0;
      if (push_ready != '0 || pop_valid != '0) begin
        errors++;
        $display("ERROR: push_ready or pop_valid is high while arst_n is low");
      end
      if (credit_count != credit_t'(INITIAL_CREDIT)) begin
        mismatches++;
        $display("MISMATCH credit_count: expected %h, got %h", INITIAL_CREDIT, credit_count);
      end
    end else if (seen_reset) begin
      if (receiver_reset) begin
        clear_expected();
        if (push_ready != '0) begin
          errors++;
          $display("ERROR: push_ready is high during receiver reset");
        end
      end
      // The pool is full again once the receiver leaves reset.
      if (rr_prev && !receiver_reset && credit_count != credit_t'(INITIAL_CREDIT)) begin
        mismatches++;
        $display("MISMATCH credit_count: expected %h, got %h", INITIAL_CREDIT, credit_count);
      end
      // Credits from last cycle's pops count as spendable now, unless the
      // receiver is in reset and returns nothing.
      exp_avail = int'(credit_count) - int'(credit_withhold);
      if (!receiver_reset) begin
        exp_avail = exp_avail + prev_pops;
      end
      if (exp_avail < 0) begin
        exp_avail = 0;
      end else if (exp_avail > MAX_CREDIT) begin
        exp_avail = MAX_CREDIT;
      end
      if (int'(credit_available) != exp_avail) begin
        mismatches++;
        $display("MISMATCH credit_available: expected %h, got %h", exp_avail, credit_available);
      end
      if (int'(credit_withhold) >= MAX_CREDIT && push_ready != '0) begin
        errors++;
        $display("ERROR: push_ready is high while every credit is withheld");
      end
      // Pops are compared against the oldest expected flit of their flow.
      for (int f = 0; f < NUM_FLOWS; f++) begin
        if (pop_valid[f] && pop_ready[f]) begin
          pops_now++;
          if (exp_rd[f] == exp_wr[f]) begin
            errors++;
            $display("ERROR: flow %0d popped a flit that was never pushed", f);
          end else begin
            if (pop_data[f] !== exp_mem[f][exp_rd[f] % EXP_DEPTH]) begin
              mismatches++;
              $display("MISMATCH pop_data[%0d]: expected %h, got %h",
                       f, exp_mem[f][exp_rd[f] % EXP_DEPTH], pop_data[f]);
            end
            exp_rd[f]++;
            outstanding--;
          end
        end
      end
      for (int f = 0; f < NUM_FLOWS; f++) begin
        if (push_valid[f] && push_ready[f]) begin
          grants_now++;
          exp_mem[f][exp_wr[f] % EXP_DEPTH] = push_data[f];
          exp_wr[f]++;
          outstanding++;
        end
      end
      if (outstanding > MAX_CREDIT) begin
        errors++;
        $display("ERROR: %0d flits in flight, more than the credit pool", outstanding);
      end
      // A waiting flow may see at most NUM_FLOWS grants go to others.
      for (int f = 0; f < NUM_FLOWS; f++) begin
        if (push_valid[f] && !push_ready[f]) begin
          wait_grants[f] = wait_grants[f] + grants_now;
          if (wait_grants[f] > NUM_FLOWS) begin
            errors++;
            $display("ERROR: flow %0d waited through %0d grants", f, wait_grants[f]);
            wait_grants[f] = 0;
          end
        end else begin
          wait_grants[f] = 0;
        end
      end
      prev_pops = pops_now;
    end
    rr_prev = receiver_reset;
    mismatch_count <= mismatches;
    error_count <= errors;
    in_flight <= outstanding;
  end

endmodule

// File: tests/credit_link_golden.txt
// One command per line. [31:28] command, [27:24] flow, [15:0] data or count.
// 1 push, 2 pop mode (0 low, 1 high, 2 random), 3 withhold, 4 reset cycles,
// 5 drain, 6 idle cycles, f end.
20000001
10001a01
11002b01
12003c01
13004d01
10001a02
11002b02
10001a03
13004d02
50000000
20000002
10005a10
10005a11
12005c10
12005c11
12005c12
11005b10
13005d10
13005d11
50000000
// Scarcity: two spendable credits, all flows requesting.
30000006
20000000
10006a00
11006b00
12006c00
13006d00
10006a01
11006b01
12006c01
13006d01
60000010
20000002
50000000
30000000
// Every credit withheld, then released.
30000008
20000001
10007a00
12007c00
6000000c
30000000
50000000
// Receiver reset drops buffered flits.
20000000
10008a00
11008b00
12008c00
6000000a
40000003
10009a00
13009d00
20000001
50000000
f0000000

// File: tests/credit_link_tb.sv
// Credit link testbench
`timescale 1ns/1ns

module credit_link_tb;
  import flit_pkg::*;
  import credit_pkg::*;

  localparam int CMD_MAX = 128;
  localparam int PUSH_DEPTH = 64;
  localparam int WAIT_LIMIT = 2000;

  logic                       clk = 1'b0;
  logic                       arst_n = 1'b1;
  logic                       receiver_reset = 1'b0;
  flow_mask_t                 push_valid = '0;
  flit_data_t [NUM_FLOWS-1:0] push_data = '0;
  credit_t                    credit_withhold = '0;
  flow_mask_t                 pop_ready = '0;
  flow_mask_t                 push_ready;
  flow_mask_t                 pop_valid;
  flit_data_t [NUM_FLOWS-1:0] pop_data;
  credit_t                    credit_count;
  credit_t                    credit_available;
  int                         mismatch_count;
  int                         error_count;
  int                         in_flight;

  // Commands from the golden file, and the flits still waiting to be pushed.
  logic [31:0] golden [CMD_MAX];
  flit_data_t  push_mem [NUM_FLOWS][PUSH_DEPTH];
  int          push_tail [NUM_FLOWS] = '{default: 0};
  int          push_head [NUM_FLOWS] = '{default: 0};
  flow_mask_t  fire_q = '0;
  logic [1:0]  pop_mode = 2'd0;
  credit_t     withhold_val = '0;
  int          reset_req = 0;
  int          reset_done = 0;
  logic [31:0] lcg_state = 32'h016a5be9;
  int          tb_errors = 0;
  int          timeouts = 0;
  logic        aborted = 1'b0;

  always #2 clk = ~clk;

  credit_link_top credit_link_top_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .receiver_reset   (receiver_reset),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .credit_withhold  (credit_withhold),
    .pop_ready        (pop_ready),
    .push_ready       (push_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  credit_link_checker checker_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .receiver_reset   (receiver_reset),
    .push_valid       (push_valid),
    .push_ready       (push_ready),
    .push_data        (push_data),
    .credit_withhold  (credit_withhold),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .credit_count     (credit_count),
    .credit_available (credit_available),
    .mismatch_count   (mismatch_count),
    .error_count      (error_count),
    .in_flight        (in_flight)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int queued_flits();
    int total;
    total = 0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      total = total + push_tail[f] - push_head[f];
    end
    return total;
  endfunction

  // ----------------------------------------
  // Input drivers
  // ----------------------------------------

  // Push handshakes are taken mid-cycle, where every signal is settled.
  always @(negedge clk) begin
    fire_q <= push_valid & push_ready;
  end

  // A flow offers its next flit as soon as the previous one was taken.
  always @(posedge clk) begin
    if (arst_n) begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        if (fire_q[f]) begin
          push_head[f] = push_head[f] + 1;
        end
        push_valid[f] <= (push_head[f] < push_tail[f]);
        push_data[f] <= push_mem[f][push_head[f] % PUSH_DEPTH];
      end
      lcg_state = lcg_next(lcg_state);
      case (pop_mode)
        2'd0: pop_ready <= '0;
        2'd1: pop_ready <= '1;
        default: pop_ready <= lcg_state[31:32-NUM_FLOWS];
      endcase
      credit_withhold <= withhold_val;
      receiver_reset <= (reset_done < reset_req);
      if (reset_done < reset_req) begin
        reset_done = reset_done + 1;
      end
    end
  end

  // Waits until every queued flit has been pushed and popped, then until the
  // returned credits have refilled the pool.
  task automatic drain_traffic();
    int t;
    t = 0;
    while (!aborted && (queued_flits() != 0 || in_flight != 0)) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) begin
        $display("TIMEOUT: traffic did not drain within %0d cycles", WAIT_LIMIT);
        timeouts++;
        aborted = 1'b1;
      end
    end
    t = 0;
    while (!aborted && credit_count != credit_t'(INITIAL_CREDIT)) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) begin
        $display("TIMEOUT: credit_count did not return to the initial credit after drain");
        timeouts++;
        aborted = 1'b1;
      end
    end
  endtask

  task automatic run_command(input logic [31:0] cmd);
    int f;
    f = int'(cmd[27:24]);
    case (cmd[31:28])
      4'h1: begin
        push_mem[f][push_tail[f] % PUSH_DEPTH] = cmd[15:0];
        push_tail[f] = push_tail[f] + 1;
      end
      4'h2: pop_mode = cmd[1:0];
      4'h3: withhold_val = cmd[CREDIT_WIDTH-1:0];
      4'h4: reset_req = reset_req + int'(cmd[7:0]);
      4'h5: drain_traffic();
      4'h6: repeat (int'(cmd[15:0])) @(negedge clk);
      default: begin
        tb_errors++;
        $display("ERROR: unknown command %h in the golden file", cmd);
      end
    endcase
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    int n;
    int total;
    int assert_errs;
    $readmemh("tests/credit_link_golden.txt", golden);
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    n = 0;
    while (!aborted && n < CMD_MAX && golden[n][31:28] != 4'hf) begin
      @(negedge clk);
      run_command(golden[n]);
      n++;
    end
    repeat (4) @(negedge clk);
    assert_errs = credit_link_top_i.credit_sender_i.credit_link_assert_i.failures;
    total = mismatch_count + error_count + tb_errors + timeouts + assert_errs;
    $display("Checks done: %0d mismatches, %0d other errors, %0d assertion failures, %0d timeouts",
             mismatch_count, error_count + tb_errors, assert_errs, timeouts);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog/credit_counter.sv
// Credit pool counter
`timescale 1ns/1ns

module credit_counter (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       reload,
  input  credit_pkg::credit_change_t incr,
  input  credit_pkg::credit_change_t decr,
  input  credit_pkg::credit_t        withhold,
  output credit_pkg::credit_t        count,
  output credit_pkg::credit_t        available
);
  import credit_pkg::*;

  credit_change_t incr_eff;
  credit_t        count_next;

  // Credits that come back while the pool is reloaded are lost on purpose.
  // The receiver is being emptied at the same time.
  assign incr_eff = reload ? '0 : incr;

  // ----------------------------------------
  // Spendable credit
  // ----------------------------------------

  // Returned credits count as spendable in the cycle they arrive.
  // Withheld credits are held back, and the result never goes below zero.
  always_comb begin
    int spendable;
    spendable = int'(count) + int'(incr_eff) - int'(withhold);
    if (spendable < 0) begin
      available = '0;
    end else if (spendable > MAX_CREDIT) begin
      available = credit_t'(MAX_CREDIT);
    end else begin
      available = credit_t'(spendable);
    end
  end

  // ----------------------------------------
  // Pool register
  // ----------------------------------------

  // The decrement never exceeds what was available, so only the upper limit
  // can be reached here, and only if the far side returns too many credits.
  always_comb begin
    int total;
    total = int'(count) + int'(incr_eff) - int'(decr);
    if (total > MAX_CREDIT) begin
      count_next = credit_t'(MAX_CREDIT);
    end else if (total < 0) begin
      count_next = '0;
    end else begin
      count_next = credit_t'(total);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= credit_t'(INITIAL_CREDIT);
    end else if (reload) begin
      count <= credit_t'(INITIAL_CREDIT);
    end else begin
      count <= count_next;
    end
  end

endmodule

// File: verilog/credit_link_if.sv
// Credit/valid link interface
`timescale 1ns/1ns

interface credit_link_if;
  import flit_pkg::*;
  import credit_pkg::*;

  // One valid bit per flow. Each set bit is a transfer, with no back-pressure.
  flow_mask_t                 valid;
  flit_data_t [NUM_FLOWS-1:0] data;
  // Number of credits handed back by the receiver this cycle.
  credit_change_t             credit;
  // Either side raises its flag while it is in reset.
  logic                       sender_in_reset;
  logic                       receiver_in_reset;

  modport sender (
    output valid,
    output data,
    output sender_in_reset,
    input  credit,
    input  receiver_in_reset
  );

  modport receiver (
    input  valid,
    input  data,
    input  sender_in_reset,
    output credit,
    output receiver_in_reset
  );

endinterface

// File: verilog/credit_link_top.sv
// Credit link top level
`timescale 1ns/1ns

module credit_link_top (
  input  logic                                           clk,
  input  logic                                           arst_n,
  input  logic                                           receiver_reset,
  input  flit_pkg::flow_mask_t                           push_valid,
  input  flit_pkg::flit_data_t [flit_pkg::NUM_FLOWS-1:0] push_data,
  input  credit_pkg::credit_t                            credit_withhold,
  input  flit_pkg::flow_mask_t                           pop_ready,
  output flit_pkg::flow_mask_t                           push_ready,
  output flit_pkg::flow_mask_t                           pop_valid,
  output flit_pkg::flit_data_t [flit_pkg::NUM_FLOWS-1:0] pop_data,
  output credit_pkg::credit_t                            credit_count,
  output credit_pkg::credit_t                            credit_available
);

  // ----------------------------------------
  // Link between the two sides
  // ----------------------------------------

  credit_link_if link_if ();

  // Sender side. Push to link is combinational.
  credit_sender credit_sender_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .credit_withhold  (credit_withhold),
    .push_ready       (push_ready),
    .credit_count     (credit_count),
    .credit_available (credit_available),
    .link             (link_if.sender)
  );

  // Receiver side. It can be reset alone through receiver_reset.
  credit_receiver credit_receiver_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .receiver_reset (receiver_reset),
    .pop_ready      (pop_ready),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data),
    .link           (link_if.receiver)
  );

endmodule

// File: verilog/credit_pkg.sv
// Credit accounting definitions
package credit_pkg;

  // ----------------------------------------
  // Credit pool sizing
  // ----------------------------------------

  // Total credits in the pool. Each flow buffer in the receiver has the same
  // depth, so one flow can hold every credit without overflow.
  // It must be a power of two for the buffer pointers to wrap cleanly.
  localparam int MAX_CREDIT = 8;
  localparam int INITIAL_CREDIT = MAX_CREDIT;

  localparam int CREDIT_WIDTH = $clog2(MAX_CREDIT + 1);
  // Up to one credit per flow is spent or returned in one cycle.
  localparam int CHANGE_WIDTH = $clog2(flit_pkg::NUM_FLOWS + 1);

  // Buffer slot index, and the same index with an extra wrap bit.
  localparam int SLOT_WIDTH = $clog2(MAX_CREDIT);
  localparam int PTR_WIDTH = SLOT_WIDTH + 1;

  typedef logic [CREDIT_WIDTH-1:0] credit_t;
  typedef logic [CHANGE_WIDTH-1:0] credit_change_t;
  typedef logic [PTR_WIDTH-1:0]    buf_ptr_t;

endpackage

// File: verilog/credit_receiver.sv
// Credit receiver
`timescale 1ns/1ns

module credit_receiver (
  input  logic                                           clk,
  input  logic                                           arst_n,
  input  logic                                           receiver_reset,
  input  flit_pkg::flow_mask_t                           pop_ready,
  output flit_pkg::flow_mask_t                           pop_valid,
  output flit_pkg::flit_data_t [flit_pkg::NUM_FLOWS-1:0] pop_data,
  credit_link_if.receiver                                link
);
  import flit_pkg::*;
  import credit_pkg::*;

  logic           reset_hold_q;
  logic           in_reset;
  logic           flush;
  flit_data_t     buf_mem [NUM_FLOWS][MAX_CREDIT];
  buf_ptr_t       wr_ptr [NUM_FLOWS];
  buf_ptr_t       rd_ptr [NUM_FLOWS];
  flow_mask_t     pop_fire;
  credit_change_t pop_count;
  credit_change_t credit_q;

  // The receiver reports reset while receiver_reset is high and for one more
  // cycle, so the sender reloads its pool after the buffers are empty.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_hold_q <= 1'b1;
    end else begin
      reset_hold_q <= receiver_reset;
    end
  end

  assign in_reset = receiver_reset || reset_hold_q;
  assign link.receiver_in_reset = in_reset;
  // A reset on either side empties the buffers.
  assign flush = in_reset || link.sender_in_reset;

  // ----------------------------------------
  // Per-flow circular buffers
  // ----------------------------------------

  // The pointers carry one wrap bit. Equal pointers mean the buffer is empty.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        wr_ptr[f] <= '0;
        rd_ptr[f] <= '0;
      end
    end else if (flush) begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        wr_ptr[f] <= '0;
        rd_ptr[f] <= '0;
      end
    end else begin
      for (int f = 0; f < NUM_FLOWS; f++) begin
        if (link.valid[f]) begin
          wr_ptr[f] <= wr_ptr[f] + 1'b1;
        end
        if (pop_fire[f]) begin
          rd_ptr[f] <= rd_ptr[f] + 1'b1;
        end
      end
    end
  end

  // Storage holds payload only.
  always_ff @(posedge clk) begin
    for (int f = 0; f < NUM_FLOWS; f++) begin
      if (link.valid[f] && !flush) begin
        buf_mem[f][wr_ptr[f][SLOT_WIDTH-1:0]] <= link.data[f];
      end
    end
  end

  // A flit written at a clock edge is visible from the next cycle on.
  always_comb begin
    for (int f = 0; f < NUM_FLOWS; f++) begin
      pop_valid[f] = (wr_ptr[f] != rd_ptr[f]) && !flush;
      pop_data[f] = buf_mem[f][rd_ptr[f][SLOT_WIDTH-1:0]];
    end
  end

  assign pop_fire = pop_valid & pop_ready;

  // ----------------------------------------
  // Credit return
  // ----------------------------------------

  // One credit goes back for every flit popped, one cycle after the pop.
  always_comb begin
    pop_count = '0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      pop_count = pop_count + credit_change_t'(pop_fire[f]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_q <= '0;
    end else if (flush) begin
      credit_q <= '0;
    end else begin
      credit_q <= pop_count;
    end
  end

  assign link.credit = in_reset ? '0 : credit_q;

endmodule

// File: verilog/credit_sender.sv
// Credit sender
`timescale 1ns/1ns

module credit_sender (
  input  logic                                       clk,
  input  logic                                       arst_n,
  input  flit_pkg::flow_mask_t                       push_valid,
  input  flit_pkg::flit_data_t [flit_pkg::NUM_FLOWS-1:0] push_data,
  input  credit_pkg::credit_t                        credit_withhold,
  output flit_pkg::flow_mask_t                       push_ready,
  output credit_pkg::credit_t                        credit_count,
  output credit_pkg::credit_t                        credit_available,
  credit_link_if.sender                              link
);
  import flit_pkg::*;
  import credit_pkg::*;

  logic           sender_in_reset_q;
  logic           either_in_reset;
  credit_change_t grant_limit;
  credit_change_t grant_count;

  // High during arst_n and for the first clock after it releases.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sender_in_reset_q <= 1'b1;
    end else begin
      sender_in_reset_q <= 1'b0;
    end
  end

  assign link.sender_in_reset = sender_in_reset_q;
  assign either_in_reset = sender_in_reset_q || link.receiver_in_reset;

  // ----------------------------------------
  // Credit pool and arbitration
  // ----------------------------------------

  // Either side in reset reloads the pool and drops returned credits.
  credit_counter credit_counter_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .reload    (either_in_reset),
    .incr      (link.credit),
    .decr      (grant_count),
    .withhold  (credit_withhold),
    .count     (credit_count),
    .available (credit_available)
  );

  // At most one flit per flow leaves per cycle, so the limit is the smaller of
  // the spendable credit and the flow count. A zero limit in reset keeps
  // push_ready low and the priority pointer still.
  always_comb begin
    if (either_in_reset) begin
      grant_limit = '0;
    end else if (credit_available < credit_t'(NUM_FLOWS)) begin
      grant_limit = credit_change_t'(credit_available);
    end else begin
      grant_limit = credit_change_t'(NUM_FLOWS);
    end
  end

  multi_grant_rr_arbiter arbiter_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .request       (push_valid),
    .grant_allowed (grant_limit),
    .grant         (push_ready),
    .grant_count   (grant_count)
  );

  // The link is driven straight from the push side with no register.
  assign link.valid = push_ready & push_valid;
  assign link.data = push_data;

endmodule

// File: verilog/flit_pkg.sv
// Flow and flit definitions
package flit_pkg;

  // ----------------------------------------
  // Flow count and payload width
  // ----------------------------------------

  // Number of independent flows that share one credit pool.
  localparam int NUM_FLOWS = 4;

  // Payload bits carried by one flit.
  localparam int DATA_WIDTH = 16;

  // Bits needed to name one flow.
  localparam int FLOW_IDX_WIDTH = (NUM_FLOWS > 1) ? $clog2(NUM_FLOWS) : 1;

  typedef logic [DATA_WIDTH-1:0]     flit_data_t;
  typedef logic [NUM_FLOWS-1:0]      flow_mask_t;
  typedef logic [FLOW_IDX_WIDTH-1:0] flow_idx_t;

endpackage

// File: verilog/multi_grant_rr_arbiter.sv
// Multi-grant round-robin arbiter
`timescale 1ns/1ns

module multi_grant_rr_arbiter (
  input  logic                       clk,
  input  logic                       arst_n,
  input  flit_pkg::flow_mask_t       request,
  input  credit_pkg::credit_change_t grant_allowed,
  output flit_pkg::flow_mask_t       grant,
  output credit_pkg::credit_change_t grant_count
);
  import flit_pkg::*;
  import credit_pkg::*;

  // Flow that has the highest priority this cycle.
  flow_idx_t prio_ptr;
  // Last flow that received a grant this cycle.
  flow_idx_t last_idx;
  flow_idx_t prio_next;

  // ----------------------------------------
  // Grant selection
  // ----------------------------------------

  // Walk the flows once, starting at the priority pointer, and grant each
  // requester in turn until the allowed number of grants is used up.
  always_comb begin
    credit_change_t granted;
    flow_idx_t      idx;
    grant = '0;
    granted = '0;
    last_idx = prio_ptr;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      idx = flow_idx_t'((int'(prio_ptr) + i) % NUM_FLOWS);
      if (request[idx] && (granted < grant_allowed)) begin
        grant[idx] = 1'b1;
        granted = granted + 1'b1;
        last_idx = idx;
      end
    end
    grant_count = granted;
  end

  // ----------------------------------------
  // Priority rotation
  // ----------------------------------------

  // The flow just after the last winner goes first next time. A flow that
  // keeps requesting is therefore passed over by at most NUM_FLOWS grants.
  assign prio_next = flow_idx_t'((int'(last_idx) + 1) % NUM_FLOWS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prio_ptr <= '0;
    end else if (|grant) begin
      prio_ptr <= prio_next;
    end
  end

endmodule

// File: vlog.f
verilog/flit_pkg.sv
verilog/credit_pkg.sv
verilog/credit_link_if.sv
verilog/credit_counter.sv
verilog/multi_grant_rr_arbiter.sv
verilog/credit_sender.sv
verilog/credit_receiver.sv
verilog/credit_link_top.sv
tests/credit_link_checker.sv
tests/credit_link_assert.sv
tests/credit_link_tb.sv
